// File: bench/cpu_asserts.sv
//==========================================================================
// Concurrent checks on the external memory bus, bound into the core top.
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module cpu_asserts (
  input wire        clk_in,
  input wire        arst_n,
  input wire        rdy_in,
  input wire [31:0] mem_a,
  input wire        mem_wr
);
  int fail_count = 0;

  // writes only happen in ready cycles
  wr_needs_rdy: assert property (@(posedge clk_in) disable iff (!arst_n)
    mem_wr |-> rdy_in)
    else begin
      fail_count++;
      $error("mem_wr high while rdy_in low");
    end

  // a paused cycle keeps the address of an outstanding read
  addr_held: assert property (@(posedge clk_in) disable iff (!arst_n)
    !rdy_in |=> $stable(mem_a))
    else begin
      fail_count++;
      $error("mem_a changed after a paused cycle");
    end

  no_wr_in_reset: assert property (@(posedge clk_in) !arst_n |-> !mem_wr)
    else begin
      fail_count++;
      $error("mem_wr high during reset");
    end

endmodule

bind cpu cpu_asserts cpu_asserts_inst (
  .clk_in(clk_in),
  .arst_n(arst_n),
  .rdy_in(rdy_in),
  .mem_a(mem_a),
  .mem_wr(mem_wr)
);

`default_nettype wire

// File: bench/cpu_checker.sv
//==========================================================================
// Watches bus writes of the core, compares them with a reference model
// and prints one result line per test, then the error counts.
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module cpu_checker (
  input  wire        clk_in,
  input  wire        arst_n,
  input  wire        mem_wr,
  input  wire [31:0] mem_a,
  input  wire [7:0]  mem_dout,
  input  wire [1:0]  run_id,
  input  wire        end_run,
  output logic       halt_seen,
  output int         err_count
);
  import rv32_pkg::*;

  localparam logic [31:0] store_base = 32'h0000_2000;
  localparam logic [31:0] trap_addr  = 32'h0003_0008;
  localparam int          n_stores   = 80;

  logic [31:0] op_a [8];
  logic [31:0] op_b [8];
  logic [31:0] seed;
  logic [31:0] word_acc;
  logic [31:0] log_a0 [$];
  logic [7:0]  log_d0 [$];
  logic [31:0] log_a1 [$];
  logic [7:0]  log_d1 [$];
  int store_cnt;
  int byte_idx;
  int out_cnt;
  int first_seen;
  int e_alu;
  int e_order;
  int e_branch;
  int e_halt;
  int e_reset;
  int e_pause;
  int tests_run;
  int tests_failed;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected result per operation index in program order
  function automatic logic [31:0] ref_alu(input int k, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (k)
      0: return a + b;
      1: return a - b;
      2: return a & b;
      3: return a | b;
      4: return a ^ b;
      5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      6: return (a < b) ? 32'd1 : 32'd0;
      7: return a << sh;
      8: return a >> sh;
      default: return $unsigned($signed(a) >>> sh);
    endcase
  endfunction

  initial begin
    seed = 32'hc323_e74b;
    for (int i = 0; i < 8; i++) begin
      seed     = lcg_next(seed);
      op_a[i]  = seed;
      seed     = lcg_next(seed);
      op_b[i]  = seed;
    end
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    e_alu        = 0;
    e_order      = 0;
    e_branch     = 0;
    e_halt       = 0;
    e_reset      = 0;
    e_pause      = 0;
  end

  task automatic record_write(input logic [31:0] a, input logic [7:0] d);
    logic [31:0] exp_addr;
    logic [31:0] exp_word;
    int idx;
    if (run_id == 2'd0) begin
      log_a0.push_back(a);
      log_d0.push_back(d);
    end else begin
      log_a1.push_back(a);
      log_d1.push_back(d);
    end
    if (halt_seen) begin
      e_halt++;
      $display("Error at %0t: write to %h after the halt write", $time, a);
    end
    if (first_seen == 0) begin
      first_seen = 1;
      if (a != store_base) begin
        e_reset++;
        $display("Mismatch at %0t: first write went to %h", $time, a);
      end
    end
    if (a == io_halt_addr) begin
      halt_seen = 1'b1;
    end else if (a == io_out_addr) begin
      if (d != 8'(out_cnt + 1)) begin
        e_branch++;
        $display("Mismatch at %0t: output byte %0d, expected %0d",
                 $time, d, out_cnt + 1);
      end
      out_cnt++;
    end else if (a == trap_addr) begin
      e_branch++;
      $display("Error at %0t: a store reached the trap address", $time);
    end else if (a >= store_base && a < store_base + 32'(n_stores * 4)) begin
      exp_addr = store_base + 32'(store_cnt * 4 + byte_idx);
      if (a != exp_addr) begin
        e_order++;
        $display("Mismatch at %0t: byte write to %h, expected %h", $time, a, exp_addr);
      end
      word_acc[byte_idx*8 +: 8] = d;
      byte_idx++;
      if (byte_idx == 4) begin
        idx      = store_cnt;
        exp_word = ref_alu(idx % 10, op_a[idx / 10], op_b[idx / 10]);
        if (word_acc != exp_word) begin
          e_alu++;
          $display("Mismatch at %0t: pair %0d op %0d got %h, expected %h",
                   $time, idx / 10, idx % 10, word_acc, exp_word);
        end
        store_cnt++;
        byte_idx = 0;
      end
    end else begin
      e_order++;
      $display("Error at %0t: write to unexpected address %h", $time, a);
    end
  endtask

  task automatic report_test(input string name, inout int errs);
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("test %-10s run %0d: %s (%0d errors)", name, run_id,
             (errs == 0) ? "pass" : "FAIL", errs);
    err_count += errs;
    errs = 0;
  endtask

  task automatic finish_run();
    if (store_cnt != n_stores) begin
      e_alu++;
      $display("Error: only %0d of %0d result words were stored", store_cnt, n_stores);
    end
    if (out_cnt != 5) begin
      e_branch++;
      $display("Error: output port got %0d bytes instead of 5", out_cnt);
    end
    report_test("alu_ops", e_alu);
    report_test("stores", e_order);
    report_test("branches", e_branch);
    report_test("halt", e_halt);
    report_test("reset", e_reset);
    if (run_id == 2'd1) begin
      if (log_a0.size() != log_a1.size()) begin
        e_pause++;
        $display("Error: paused run wrote %0d bytes, first run %0d",
                 log_a1.size(), log_a0.size());
      end else begin
        for (int i = 0; i < log_a0.size(); i++) begin
          if (log_a0[i] != log_a1[i] || log_d0[i] != log_d1[i]) begin
            e_pause++;
            $display("Mismatch at %0t: write %0d differs between runs", $time, i);
          end
        end
      end
      report_test("pause", e_pause);
      $display("tests run: %0d, tests failed: %0d, errors: %0d",
               tests_run, tests_failed, err_count);
    end
  endtask

  always @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      store_cnt  = 0;
      byte_idx   = 0;
      out_cnt    = 0;
      first_seen = 0;
      halt_seen  = 1'b0;
    end else if (mem_wr) begin
      record_write(mem_a, mem_dout);
    end
  end

  always @(posedge clk_in) begin
    if (end_run) finish_run();
  end

endmodule

`default_nettype wire

// File: bench/tb_cpu.sv
//==========================================================================
// Testbench for the RV32I core: memory model, program builder, two runs
// (the second with random pauses on rdy_in) and a watchdog.
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;
  import rv32_pkg::*;

  logic        clk_in;
  logic        arst_n;
  logic        rdy_in;
  logic [7:0]  mem_din;
  logic [7:0]  mem_dout;
  logic [31:0] mem_a;
  logic        mem_wr;
  logic [1:0]  run_id;
  logic        end_run;
  logic        halt_seen;
  int          err_count;

  logic [7:0]  mem [0:131071];
  logic [16:0] rd_addr_q;
  logic [31:0] pause_seed;
  logic        pause_mode;
  logic        built;
  logic [31:0] pc;
  int          n_static;
  int          dyn_instr;
  longint      wd_ns;

  cpu #(
    .mem_addr_bits(18)
  ) cpu_inst (
    .clk_in(clk_in),
    .arst_n(arst_n),
    .rdy_in(rdy_in),
    .mem_din(mem_din),
    .mem_dout(mem_dout),
    .mem_a(mem_a),
    .mem_wr(mem_wr)
  );

  cpu_checker cpu_checker_inst (
    .clk_in(clk_in),
    .arst_n(arst_n),
    .mem_wr(mem_wr),
    .mem_a(mem_a),
    .mem_dout(mem_dout),
    .run_id(run_id),
    .end_run(end_run),
    .halt_seen(halt_seen),
    .err_count(err_count)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, op_lui};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  // funct fields for ADD SUB AND OR XOR SLT SLTU SLL SRL SRA
  function automatic logic [2:0] funct3_of(input int k);
    logic [2:0] t [10] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100,
                          3'b010, 3'b011, 3'b001, 3'b101, 3'b101};
    return t[k];
  endfunction

  function automatic logic [6:0] funct7_of(input int k);
    return (k == 1 || k == 9) ? 7'h20 : 7'h00;
  endfunction

  task automatic put_word(input logic [31:0] a, input logic [31:0] w);
    for (int i = 0; i < 4; i++) begin
      mem[a[16:0] + 17'(i)] = w[i*8 +: 8];
    end
  endtask

  task automatic emit(input logic [31:0] w);
    put_word(pc, w);
    pc = pc + 32'd4;
    n_static++;
  endtask

  task automatic load_program();
    logic [31:0] s;
    for (int i = 0; i < 131072; i++) begin
      mem[i] = 8'(i ^ (i >> 8) ^ (i >> 16));
    end
    s = 32'hc323_e74b;
    for (int i = 0; i < 8; i++) begin
      s = lcg_next(s);
      put_word(32'h1000 + 32'(8 * i), s);
      s = lcg_next(s);
      put_word(32'h1004 + 32'(8 * i), s);
    end
    pc       = 32'd0;
    n_static = 0;
    // x1 holds the operand base and x2 the result base
    emit(u_type(20'h1, 5'd1));
    emit(u_type(20'h2, 5'd2));
    for (int i = 0; i < 8; i++) begin
      emit(i_type(12'(8 * i), 5'd1, 3'b010, 5'd3, op_load));
      emit(i_type(12'(8 * i + 4), 5'd1, 3'b010, 5'd4, op_load));
      for (int k = 0; k < 10; k++) begin
        emit(r_type(funct7_of(k), 5'd4, 5'd3, funct3_of(k), 5'd5));
        emit(s_type(12'(4 * (i * 10 + k)), 5'd5, 5'd2, 3'b010));
      end
    end
    // counter loop over the output port
    // JAL skips the trap store
    emit(i_type(12'd0, 5'd0, 3'b000, 5'd6, op_imm));
    emit(i_type(12'd5, 5'd0, 3'b000, 5'd7, op_imm));
    emit(u_type(20'h30, 5'd8));
    emit(i_type(12'd1, 5'd6, 3'b000, 5'd6, op_imm));
    emit(s_type(12'd0, 5'd6, 5'd8, 3'b000));
    emit(j_type(21'd8, 5'd0));
    emit(s_type(12'd8, 5'd6, 5'd8, 3'b000));
    emit(b_type(-13'sd16, 5'd7, 5'd6, 3'b001));
    emit(s_type(12'd4, 5'd0, 5'd8, 3'b000));
    dyn_instr = n_static + 4 * 4;
  endtask

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  // read data returns in the next cycle and holds while paused
  always @(posedge clk_in) begin
    if (rdy_in) begin
      if (mem_wr && mem_a[17:16] != 2'b11) mem[mem_a[16:0]] = mem_dout;
      rd_addr_q = mem_a[16:0];
    end
  end

  always @(negedge clk_in) begin
    mem_din = mem[rd_addr_q];
    if (pause_mode) begin
      pause_seed = lcg_next(pause_seed);
      rdy_in = (pause_seed[31:30] != 2'b00);
    end else begin
      rdy_in = 1'b1;
    end
  end

  task automatic do_run(input int r);
    @(posedge clk_in);
    pause_mode = (r == 1);
    @(negedge clk_in);
    arst_n = 1'b0;
    run_id = 2'(r);
    if (r == 1) load_program();
    repeat (4) @(negedge clk_in);
    arst_n = 1'b1;
    wait (halt_seen);
    // halt must stay quiet for a while
    repeat (20) @(negedge clk_in);
    end_run = 1'b1;
    @(negedge clk_in);
    end_run = 1'b0;
    @(negedge clk_in);
  endtask

  initial begin
    arst_n     = 1'b0;
    rdy_in     = 1'b1;
    mem_din    = 8'd0;
    run_id     = 2'd0;
    end_run    = 1'b0;
    pause_mode = 1'b0;
    pause_seed = 32'hc323_e74b;
    rd_addr_q  = '0;
    built      = 1'b0;
    load_program();
    built = 1'b1;
    do_run(0);
    do_run(1);
    if (err_count == 0 && cpu_inst.cpu_asserts_inst.fail_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // two runs at 15 cycles worst case per instruction, doubled
  initial begin
    wait (built);
    wd_ns = longint'(dyn_instr) * 2 * 15 * 2 * 100 + 20000;
    #(wd_ns);
    $display("Error: the program never halted before the watchdog limit");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f verilog.f -o sim_cpu

./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with no errors" sim.log; then
  exit 0
fi
exit 1

// File: src/alu.sv
//==========================================================================
// Combinational integer ALU for register and immediate forms.
// zero flags equal operands for BEQ and BNE.
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  rv32_pkg::alu_op_t         op,
  input  wire  [rv32_pkg::xlen-1:0] a,
  input  wire  [rv32_pkg::xlen-1:0] b,
  output logic [rv32_pkg::xlen-1:0] result,
  output logic                      zero
);
  import rv32_pkg::*;

  logic [4:0] shamt;

  // only the low five bits shift
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      alu_sltu:   result = {{(xlen-1){1'b0}}, a < b};
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $unsigned($signed(a) >>> shamt);
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  assign zero = (a == b);

endmodule

`default_nettype wire

// File: src/core_sequencer.sv
//==========================================================================
// Multicycle control: owns pc and instruction register and steps each
// instruction through fetch, decode, execute, memory and writeback.
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module core_sequencer (
  input  wire                       clk_in,
  input  wire                       arst_n,
  input  wire                       rdy_in,

  output logic                      req,
  output logic                      req_write,
  output logic                      req_byte,
  output logic [rv32_pkg::xlen-1:0] req_addr,
  output logic [rv32_pkg::xlen-1:0] req_wdata,
  input  wire                       done,
  input  wire  [rv32_pkg::xlen-1:0] rdata,

  output logic [rv32_pkg::xlen-1:0] instr,
  input  wire  [4:0]                rd,
  input  wire  [rv32_pkg::xlen-1:0] imm,
  input  rv32_pkg::alu_op_t         alu_op,
  input  wire                       use_imm,
  input  wire                       is_load,
  input  wire                       is_store,
  input  wire                       store_byte,
  input  wire                       is_branch,
  input  wire                       branch_ne,
  input  wire                       is_jal,
  input  wire                       writes_rd,

  input  wire  [rv32_pkg::xlen-1:0] rs1_data,
  input  wire  [rv32_pkg::xlen-1:0] rs2_data,
  output rv32_pkg::alu_op_t         exec_op,
  output logic [rv32_pkg::xlen-1:0] exec_a,
  output logic [rv32_pkg::xlen-1:0] exec_b,
  input  wire  [rv32_pkg::xlen-1:0] alu_result,
  input  wire                       alu_zero,

  output logic                      we,
  output logic [4:0]                waddr,
  output logic [rv32_pkg::xlen-1:0] wdata
);
  import rv32_pkg::*;

  seq_state_t      state;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] result_q;
  logic            halt_pending;
  logic            taken;
  logic [xlen-1:0] link;

  assign link  = pc + 32'd4;
  // operands still latched, so zero reflects rs1 == rs2
  assign taken = is_jal | (is_branch & (alu_zero ^ branch_ne));

  // bus is only used in fetch and mem
  assign req       = (state == st_fetch) | (state == st_mem);
  assign req_write = (state == st_mem) & is_store;
  assign req_byte  = (state == st_mem) & store_byte;
  assign req_addr  = (state == st_mem) ? result_q : pc;
  assign req_wdata = rs2_data;

  assign we    = (state == st_writeback) & writes_rd;
  assign waddr = rd;
  assign wdata = is_jal ? link : result_q;

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      state        <= st_fetch;
      pc           <= '0;
      halt_pending <= 1'b0;
    end else if (rdy_in) begin
      case (state)
        st_fetch: begin
          if (done) state <= st_decode;
        end
        st_decode: begin
          state <= st_execute;
        end
        st_execute: begin
          // byte store to the halt port ends the program
          halt_pending <= is_store & store_byte & (alu_result == io_halt_addr);
          state        <= (is_load | is_store) ? st_mem : st_writeback;
        end
        st_mem: begin
          if (done) state <= st_writeback;
        end
        st_writeback: begin
          pc    <= taken ? pc + imm : link;
          state <= halt_pending ? st_halted : st_fetch;
        end
        default: begin
          state <= st_halted;
        end
      endcase
    end
  end

  // instruction, operands and result
  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (state == st_fetch && done) instr <= rdata;
      if (state == st_decode) begin
        exec_op <= alu_op;
        exec_a  <= rs1_data;
        exec_b  <= use_imm ? imm : rs2_data;
      end
      if (state == st_execute) result_q <= alu_result;
      // load data replaces the address
      if (state == st_mem && done && is_load) result_q <= rdata;
    end
  end

endmodule

`default_nettype wire

// File: src/cpu.sv
//==========================================================================
// RV32I core top level on the byte-wide memory bus.
// rdy_in low freezes the whole core.
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module cpu #(
  parameter int mem_addr_bits = 18
) (
  input  wire         clk_in,
  input  wire         arst_n,
  input  wire         rdy_in,

  input  wire  [7:0]  mem_din,
  output logic [7:0]  mem_dout,
  // only the low mem_addr_bits are driven
  output logic [31:0] mem_a,
  output logic        mem_wr
);
  import rv32_pkg::*;

  // sequencer to bus port
  logic            req;
  logic            req_write;
  logic            req_byte;
  logic [xlen-1:0] req_addr;
  logic [xlen-1:0] req_wdata;
  logic            done;
  logic [xlen-1:0] rdata;

  // decoded fields
  logic [xlen-1:0] instr;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [4:0]      rd;
  logic [xlen-1:0] imm;
  alu_op_t         alu_op;
  logic            use_imm;
  logic            is_load;
  logic            is_store;
  logic            store_byte;
  logic            is_branch;
  logic            branch_ne;
  logic            is_jal;
  logic            writes_rd;

  // execute and register paths
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  alu_op_t         exec_op;
  logic [xlen-1:0] exec_a;
  logic [xlen-1:0] exec_b;
  logic [xlen-1:0] alu_result;
  logic            alu_zero;
  logic            we;
  logic [4:0]      waddr;
  logic [xlen-1:0] wdata;

  mem_bus_port #(
    .mem_addr_bits(mem_addr_bits)
  ) mem_bus_port_inst (
    .clk_in(clk_in),       .arst_n(arst_n),     .rdy_in(rdy_in),
    .req(req),             .req_write(req_write), .req_byte(req_byte),
    .req_addr(req_addr),   .req_wdata(req_wdata),
    .done(done),           .rdata(rdata),
    .mem_din(mem_din),     .mem_dout(mem_dout),
    .mem_a(mem_a),         .mem_wr(mem_wr)
  );

  core_sequencer core_sequencer_inst (
    .clk_in(clk_in),       .arst_n(arst_n),     .rdy_in(rdy_in),
    .req(req),             .req_write(req_write), .req_byte(req_byte),
    .req_addr(req_addr),   .req_wdata(req_wdata),
    .done(done),           .rdata(rdata),
    .instr(instr),         .rd(rd),             .imm(imm),
    .alu_op(alu_op),       .use_imm(use_imm),   .is_load(is_load),
    .is_store(is_store),   .store_byte(store_byte), .is_branch(is_branch),
    .branch_ne(branch_ne), .is_jal(is_jal),     .writes_rd(writes_rd),
    .rs1_data(rs1_data),   .rs2_data(rs2_data),
    .exec_op(exec_op),     .exec_a(exec_a),     .exec_b(exec_b),
    .alu_result(alu_result), .alu_zero(alu_zero),
    .we(we),               .waddr(waddr),       .wdata(wdata)
  );

  instr_decoder instr_decoder_inst (
    .instr(instr),         .rs1(rs1),           .rs2(rs2),
    .rd(rd),               .imm(imm),           .alu_op(alu_op),
    .use_imm(use_imm),     .is_load(is_load),   .is_store(is_store),
    .store_byte(store_byte), .is_branch(is_branch), .branch_ne(branch_ne),
    .is_jal(is_jal),       .writes_rd(writes_rd)
  );

  alu alu_inst (
    .op(exec_op),          .a(exec_a),          .b(exec_b),
    .result(alu_result),   .zero(alu_zero)
  );

  reg_file reg_file_inst (
    .clk_in(clk_in),       .arst_n(arst_n),     .rdy_in(rdy_in),
    .raddr1(rs1),          .raddr2(rs2),
    .we(we),               .waddr(waddr),       .wdata(wdata),
    .rdata1(rs1_data),     .rdata2(rs2_data)
  );

endmodule

`default_nettype wire

// File: src/instr_decoder.sv
//==========================================================================
// Combinational decode of one RV32I instruction word into register
// numbers, immediate, ALU operation and control flags.
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
  input  wire  [rv32_pkg::xlen-1:0] instr,
  output logic [4:0]                rs1,
  output logic [4:0]                rs2,
  output logic [4:0]                rd,
  output logic [rv32_pkg::xlen-1:0] imm,
  output rv32_pkg::alu_op_t         alu_op,
  output logic                      use_imm,
  output logic                      is_load,
  output logic                      is_store,
  output logic                      store_byte,
  output logic                      is_branch,
  output logic                      branch_ne,
  output logic                      is_jal,
  output logic                      writes_rd
);
  import rv32_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  alu_op_t         f3_op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct3 map shared by register and immediate forms
  always_comb begin
    case (funct3)
      3'b000:  f3_op = alu_add;
      3'b001:  f3_op = alu_sll;
      3'b010:  f3_op = alu_slt;
      3'b011:  f3_op = alu_sltu;
      3'b100:  f3_op = alu_xor;
      3'b101:  f3_op = instr[30] ? alu_sra : alu_srl;
      3'b110:  f3_op = alu_or;
      default: f3_op = alu_and;
    endcase
  end

  always_comb begin
    // unknown opcodes fall through as a no-op
    imm        = '0;
    alu_op     = alu_add;
    use_imm    = 1'b0;
    is_load    = 1'b0;
    is_store   = 1'b0;
    store_byte = 1'b0;
    is_branch  = 1'b0;
    branch_ne  = funct3[0];
    is_jal     = 1'b0;
    writes_rd  = 1'b0;
    case (opcode)
      op_lui: begin
        imm       = imm_u;
        alu_op    = alu_pass_b;
        use_imm   = 1'b1;
        writes_rd = 1'b1;
      end
      op_imm: begin
        imm       = imm_i;
        alu_op    = f3_op;
        use_imm   = 1'b1;
        writes_rd = 1'b1;
      end
      op_reg: begin
        alu_op    = (funct3 == 3'b000 && instr[30]) ? alu_sub : f3_op;
        writes_rd = 1'b1;
      end
      op_load: begin
        imm       = imm_i;
        use_imm   = 1'b1;
        is_load   = (funct3 == 3'b010);
        writes_rd = (funct3 == 3'b010);
      end
      op_store: begin
        imm        = imm_s;
        use_imm    = 1'b1;
        is_store   = (funct3 == 3'b000) || (funct3 == 3'b010);
        store_byte = (funct3 == 3'b000);
      end
      op_branch: begin
        imm       = imm_b;
        is_branch = (funct3[2:1] == 2'b00);
      end
      op_jal: begin
        imm       = imm_j;
        is_jal    = 1'b1;
        writes_rd = 1'b1;
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/mem_bus_port.sv
//==========================================================================
// Breaks word and byte requests into byte cycles on the external memory
// bus. Bytes go least significant first; reads return a cycle later.
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module mem_bus_port #(
  parameter int mem_addr_bits = 18
) (
  input  wire                       clk_in,
  input  wire                       arst_n,
  input  wire                       rdy_in,

  input  wire                       req,
  input  wire                       req_write,
  input  wire                       req_byte,
  input  wire [rv32_pkg::xlen-1:0]  req_addr,
  input  wire [rv32_pkg::xlen-1:0]  req_wdata,
  output logic                      done,
  output logic [rv32_pkg::xlen-1:0] rdata,

  input  wire [7:0]                 mem_din,
  output logic [7:0]                mem_dout,
  output logic [rv32_pkg::xlen-1:0] mem_a,
  output logic                      mem_wr
);
  import rv32_pkg::*;

  logic [2:0]      cnt;
  logic [23:0]     rd_buf;
  logic            last;
  logic [1:0]      offset;
  logic [xlen-1:0] byte_addr;

  // final cycle of each transaction kind
  always_comb begin
    if (req_write) begin
      last = req_byte ? (cnt == 3'd0) : (cnt == 3'd3);
    end else begin
      last = req_byte ? (cnt == 3'd1) : (cnt == 3'd4);
    end
  end

  // hold the last byte address while its data returns
  assign offset    = req_byte ? 2'd0 : (cnt[2] ? 2'd3 : cnt[1:0]);
  assign byte_addr = req_addr + {{(xlen-2){1'b0}}, offset};

  assign mem_a    = {{(xlen-mem_addr_bits){1'b0}}, byte_addr[mem_addr_bits-1:0]};
  assign mem_dout = req_wdata[{offset, 3'b000} +: 8];
  assign mem_wr   = req & req_write & rdy_in;

  assign done  = req & rdy_in & last;
  // top byte comes straight off the bus in the done cycle
  assign rdata = req_byte ? {24'b0, mem_din} : {mem_din, rd_buf};

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= 3'd0;
    end else if (rdy_in && req) begin
      cnt <= last ? 3'd0 : cnt + 3'd1;
    end
  end

  // lower three bytes, one cycle after each address
  always_ff @(posedge clk_in) begin
    if (rdy_in && req && !req_write && cnt != 3'd0 && !cnt[2]) begin
      rd_buf[{cnt[1:0] - 2'd1, 3'b000} +: 8] <= mem_din;
    end
  end

endmodule

`default_nettype wire

// File: src/reg_file.sv
//==========================================================================
// Integer register file, two async read ports and one write port.
// x0 ignores writes and always reads zero.
//==========================================================================
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  wire                       clk_in,
  input  wire                       arst_n,
  input  wire                       rdy_in,
  input  wire  [4:0]                raddr1,
  input  wire  [4:0]                raddr2,
  input  wire                       we,
  input  wire  [4:0]                waddr,
  input  wire  [rv32_pkg::xlen-1:0] wdata,
  output logic [rv32_pkg::xlen-1:0] rdata1,
  output logic [rv32_pkg::xlen-1:0] rdata2
);
  import rv32_pkg::*;

  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rdy_in && we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: src/rv32_pkg.sv
//==========================================================================
// Shared types and constants for the multicycle RV32I core.
// Imported by every core unit and by the bench.
//==========================================================================
`default_nettype none

package rv32_pkg;

  // data and address width
  parameter int xlen = 32;

  // ALU operations, pass_b serves LUI
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_b
  } alu_op_t;

  // sequencer FSM states
  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_execute,
    st_mem,
    st_writeback,
    st_halted
  } seq_state_t;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

  // memory mapped I/O, bits 17:16 set
  localparam logic [31:0] io_out_addr  = 32'h0003_0000;
  localparam logic [31:0] io_halt_addr = 32'h0003_0004;

endpackage

`default_nettype wire

// File: verilog.f
src/rv32_pkg.sv
src/mem_bus_port.sv
src/core_sequencer.sv
src/instr_decoder.sv
src/alu.sv
src/reg_file.sv
src/cpu.sv
bench/cpu_asserts.sv
bench/cpu_checker.sv
bench/tb_cpu.sv
